// File: interrupt_controller.sv
`include "irq_cfg.svh"

module interrupt_controller (
    input  logic                 clk,
    input  logic                 nrst,
    input  irq_pkg::pc_t         pc,
    input  irq_pkg::opcode_t     if_opcode,
    input  logic                 interrupt_n,
    input  logic                 irq_enable,
    input  irq_pkg::correction_t exe_correction,
    input  logic                 if_prediction,
    input  logic                 id_sel_pc,
    input  logic                 if_clk_en,
    output logic                 isr_stall,
    output logic                 sel_isr,
    output logic                 ret_isr,
    output irq_pkg::pc_t         save_pc
);

    irq_pkg::irq_state_t state;
    irq_pkg::drain_cnt_t drain_cnt;
    logic                armed;
    logic                uret_op;
    logic                in_drain;
    logic                irq_req;
    logic                redirect;
    logic                save_en;

    // --------------------------------------------------
    // request and stall decode
    // --------------------------------------------------

    assign uret_op  = (if_opcode == `IRQ_URET_OP);
    assign in_drain = (state == irq_pkg::ENTER_DRAIN) || (state == irq_pkg::RET_DRAIN);

    // fetch stalls while draining, and at once when a URET shows up.
    assign isr_stall = in_drain || uret_op;

    // a request is only taken from idle, once per low period.
    assign irq_req = (state == irq_pkg::IDLE) && !interrupt_n && irq_enable && armed;

    // any change of flow coming down the pipe.
    assign redirect = (exe_correction != '0) || if_prediction || id_sel_pc;

    // keep the request pc, or the redirect target seen during a drain.
    assign save_en = irq_req || (isr_stall && redirect);

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= irq_pkg::IDLE;
            drain_cnt <= '0;
            sel_isr   <= 1'b0;
            ret_isr   <= 1'b0;
        end else begin
            case (state)
                irq_pkg::IDLE: begin
                    if (irq_req) begin
                        state     <= irq_pkg::ENTER_DRAIN;
                        drain_cnt <= irq_pkg::drain_cnt_t'(1);
                    end
                end
                irq_pkg::ENTER_DRAIN: begin
                    // pipeline is empty, switch fetch to the handler.
                    if (drain_cnt == `IRQ_ENTER_CNT) begin
                        state     <= irq_pkg::IN_ISR;
                        drain_cnt <= '0;
                        sel_isr   <= 1'b1;
                    end else if (if_clk_en) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                irq_pkg::IN_ISR: begin
                    if (uret_op) begin
                        state     <= irq_pkg::RET_DRAIN;
                        drain_cnt <= irq_pkg::drain_cnt_t'(1);
                        sel_isr   <= 1'b0;
                        ret_isr   <= 1'b1;
                    end
                end
                irq_pkg::RET_DRAIN: begin
                    // falling ret_isr tells fetch to reload save_pc.
                    if (drain_cnt == `IRQ_RET_CNT) begin
                        state     <= irq_pkg::IDLE;
                        drain_cnt <= '0;
                        ret_isr   <= 1'b0;
                    end else if (if_clk_en) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= irq_pkg::IDLE;
                end
            endcase
        end
    end

    // request arming, cleared on entry.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            armed <= 1'b1;
        end else if (irq_req) begin
            armed <= 1'b0;
        end else if (interrupt_n && !in_drain) begin
            armed <= 1'b1;
        end
    end

    // --------------------------------------------------
    // return address
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            save_pc <= '0;
        end else if (save_en) begin
            save_pc <= pc;
        end
    end

endmodule

// File: irq_cfg.svh
`ifndef IRQ_CFG_SVH
`define IRQ_CFG_SVH

// datapath widths.
`define IRQ_PC_W        12
`define IRQ_OPCODE_W    7
`define IRQ_CORR_W      2
`define IRQ_CNT_W       3
`define IRQ_ADDR_W      1

// SYSTEM opcode, seen in fetch when a URET comes along.
`define IRQ_URET_OP     7'h73

// pipeline drain lengths for entry and return.
`define IRQ_ENTER_CNT   3'd3
`define IRQ_RET_CNT     3'd2

// register map and reset values.
`define IRQ_RST_VECTOR  12'h100
`define IRQ_REG_VECTOR  1'b0
`define IRQ_REG_CTRL    1'b1

`endif

// File: irq_core_assert.sv
`include "irq_cfg.svh"

module irq_core_assert (
    input logic                 clk,
    input logic                 nrst,
    input logic                 interrupt_n,
    input irq_pkg::opcode_t     if_opcode,
    input logic                 if_clk_en,
    input irq_pkg::correction_t exe_correction,
    input irq_pkg::pc_t         exe_target,
    input logic                 id_sel_pc,
    input irq_pkg::pc_t         id_target,
    input logic                 if_prediction,
    input irq_pkg::pc_t         pred_target,
    input logic                 wr_en,
    input irq_pkg::reg_addr_t   wr_addr,
    input irq_pkg::pc_t         wr_data,
    input irq_pkg::reg_addr_t   rd_addr,
    input irq_pkg::pc_t         pc,
    input irq_pkg::pc_t         rd_data,
    input logic                 isr_stall,
    input logic                 sel_isr,
    input logic                 ret_isr,
    input irq_pkg::pc_t         save_pc,
    input logic                 irq_enable,
    input irq_pkg::pc_t         isr_vector
);
    timeunit 1ns;
    timeprecision 100ps;

    int           err_count = 0;
    logic         uret_op;
    logic         redirect;
    logic         armed_m;
    logic         req;
    logic         req_d1;
    logic         req_d2;
    logic         req_d3;
    logic         sel_q_m;
    logic         ret_q_m;
    logic         steer;
    logic         en_m;
    irq_pkg::pc_t vec_m;
    irq_pkg::pc_t rd_exp;
    irq_pkg::pc_t pc_q;
    irq_pkg::pc_t save_pc_q;
    irq_pkg::pc_t exe_target_q;
    irq_pkg::pc_t id_target_q;
    irq_pkg::pc_t pred_target_q;
    irq_pkg::pc_t isr_vector_q;
    irq_pkg::pc_t wr_data_q;

    // --------------------------------------------------
    // reference model of request and edge detection
    // --------------------------------------------------

    assign uret_op  = (if_opcode == `IRQ_URET_OP);
    assign redirect = (exe_correction != '0) || id_sel_pc || if_prediction;

    // idle means no drain, no handler and no pending return.
    assign req = !interrupt_n && irq_enable && armed_m && !isr_stall && !sel_isr && !ret_isr;

    // normal fetch steering, no handler entry or return edge pending.
    assign steer = if_clk_en && !(sel_isr && !sel_q_m) && !(!ret_isr && ret_q_m);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            armed_m <= 1'b1;
            sel_q_m <= 1'b0;
            ret_q_m <= 1'b0;
            req_d1  <= 1'b0;
            req_d2  <= 1'b0;
            req_d3  <= 1'b0;
        end else begin
            if (req) begin
                armed_m <= 1'b0;
            end else if (interrupt_n && !(isr_stall && !sel_isr)) begin
                armed_m <= 1'b1;
            end
            if (if_clk_en) begin
                sel_q_m <= sel_isr;
                ret_q_m <= ret_isr;
            end
            // request followed by two enabled edges.
            req_d1 <= req;
            req_d2 <= req_d1 && if_clk_en;
            req_d3 <= req_d2 && if_clk_en;
        end
    end

    // registers as last written, starting from their reset values.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            vec_m <= `IRQ_RST_VECTOR;
            en_m  <= 1'b0;
        end else if (wr_en && (wr_addr == `IRQ_REG_VECTOR)) begin
            vec_m <= wr_data;
        end else if (wr_en && (wr_addr == `IRQ_REG_CTRL)) begin
            en_m <= wr_data[0];
        end
    end

    // control reads back the enable bit alone.
    assign rd_exp = (rd_addr == `IRQ_REG_VECTOR) ? vec_m : irq_pkg::pc_t'(en_m);

    // one cycle history of the values that get loaded.
    always_ff @(posedge clk) begin
        pc_q          <= pc;
        save_pc_q     <= save_pc;
        exe_target_q  <= exe_target;
        id_target_q   <= id_target;
        pred_target_q <= pred_target;
        isr_vector_q  <= isr_vector;
        wr_data_q     <= wr_data;
    end

    // --------------------------------------------------
    // reset and registers
    // --------------------------------------------------

    a_reset: assert property (@(posedge clk) $rose(nrst) |->
        (pc == '0) && !sel_isr && !ret_isr && (isr_stall == uret_op))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, sel_isr = %h, ret_isr = %h, isr_stall = %h after reset",
                pc, sel_isr, ret_isr, isr_stall);
        end

    a_wr_vec: assert property (@(posedge clk) disable iff (!nrst)
        (wr_en && (wr_addr == `IRQ_REG_VECTOR)) |=> (isr_vector == wr_data_q))
        else begin
            err_count = err_count + 1;
            $error("Error isr_vector = %h, expected %h", isr_vector, wr_data_q);
        end

    a_wr_ctrl: assert property (@(posedge clk) disable iff (!nrst)
        (wr_en && (wr_addr == `IRQ_REG_CTRL)) |=> (irq_enable == wr_data_q[0]))
        else begin
            err_count = err_count + 1;
            $error("Error irq_enable = %h, expected %h", irq_enable, wr_data_q[0]);
        end

    a_rd: assert property (@(posedge clk) disable iff (!nrst) rd_data == rd_exp)
        else begin
            err_count = err_count + 1;
            $error("Error rd_data = %h, expected %h at address %h", rd_data, rd_exp, rd_addr);
        end

    a_masked: assert property (@(posedge clk) disable iff (!nrst)
        (!irq_enable && !isr_stall && !sel_isr && !ret_isr) |=> (!isr_stall || uret_op))
        else begin
            err_count = err_count + 1;
            $error("Error isr_stall = %h while the interrupt is masked", isr_stall);
        end

    // --------------------------------------------------
    // entry, return address and return
    // --------------------------------------------------

    a_entry_stall: assert property (@(posedge clk) disable iff (!nrst) req |=> isr_stall)
        else begin
            err_count = err_count + 1;
            $error("Error isr_stall = %h, expected 1 after the request", isr_stall);
        end

    a_entry_sel: assert property (@(posedge clk) disable iff (!nrst)
        req_d3 |=> ($rose(sel_isr) && !isr_stall))
        else begin
            err_count = err_count + 1;
            $error("Error sel_isr = %h, isr_stall = %h at handler entry", sel_isr, isr_stall);
        end

    a_entry_pc: assert property (@(posedge clk) disable iff (!nrst)
        (sel_isr && !sel_q_m && if_clk_en) |=> (pc == isr_vector_q))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, isr_vector_q);
        end

    a_save: assert property (@(posedge clk) disable iff (!nrst)
        (req || (isr_stall && redirect)) |=> (save_pc == pc_q))
        else begin
            err_count = err_count + 1;
            $error("Error save_pc = %h, expected %h", save_pc, pc_q);
        end

    a_uret_stall: assert property (@(posedge clk) disable iff (!nrst) uret_op |-> isr_stall)
        else begin
            err_count = err_count + 1;
            $error("Error isr_stall = %h with URET in fetch", isr_stall);
        end

    a_uret_ret: assert property (@(posedge clk) disable iff (!nrst)
        (sel_isr && uret_op) |=> ret_isr)
        else begin
            err_count = err_count + 1;
            $error("Error ret_isr = %h, expected 1 after URET", ret_isr);
        end

    a_ret_pc: assert property (@(posedge clk) disable iff (!nrst)
        (!ret_isr && ret_q_m && if_clk_en) |=> (pc == save_pc_q))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, save_pc_q);
        end

    // --------------------------------------------------
    // redirect priority
    // --------------------------------------------------

    a_corr: assert property (@(posedge clk) disable iff (!nrst)
        (steer && (exe_correction != '0)) |=> (pc == exe_target_q))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, exe_target_q);
        end

    a_id: assert property (@(posedge clk) disable iff (!nrst)
        (steer && (exe_correction == '0) && id_sel_pc) |=> (pc == id_target_q))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, id_target_q);
        end

    a_pred: assert property (@(posedge clk) disable iff (!nrst)
        (steer && (exe_correction == '0) && !id_sel_pc && if_prediction)
        |=> (pc == pred_target_q))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, pred_target_q);
        end

    a_hold: assert property (@(posedge clk) disable iff (!nrst)
        ((steer && !redirect && isr_stall) || !if_clk_en) |=> (pc == pc_q))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, pc_q);
        end

    a_step: assert property (@(posedge clk) disable iff (!nrst)
        (steer && !redirect && !isr_stall) |=> (pc == irq_pkg::pc_t'(pc_q + 1'b1)))
        else begin
            err_count = err_count + 1;
            $error("Error pc = %h, expected %h", pc, irq_pkg::pc_t'(pc_q + 1'b1));
        end

endmodule

// File: irq_core_tb.sv
`include "irq_cfg.svh"

module irq_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // run length, directed part plus the rounds with fetch gaps.
    localparam int DIRECTED_CYCLES = 60;
    localparam int ROUNDS          = 6;
    localparam int ROUND_CYCLES    = 65;
    localparam int WATCHDOG_CYCLES = 4 * (DIRECTED_CYCLES + ROUNDS * ROUND_CYCLES);

    logic                 clk;
    logic                 nrst;
    logic                 interrupt_n;
    logic                 if_clk_en;
    logic                 id_sel_pc;
    logic                 if_prediction;
    logic                 wr_en;
    logic                 isr_stall;
    logic                 sel_isr;
    logic                 ret_isr;
    irq_pkg::opcode_t     if_opcode;
    irq_pkg::correction_t exe_correction;
    irq_pkg::pc_t         exe_target;
    irq_pkg::pc_t         id_target;
    irq_pkg::pc_t         pred_target;
    irq_pkg::pc_t         wr_data;
    irq_pkg::pc_t         pc;
    irq_pkg::pc_t         rd_data;
    irq_pkg::pc_t         save_pc;
    irq_pkg::reg_addr_t   wr_addr;
    irq_pkg::reg_addr_t   rd_addr;
    logic [31:0]          lfsr_state = 32'h160dd785;

    bind irq_core_top irq_core_assert chk0 (.*);

    irq_core_top dut0 (.*);

    always #50 clk = ~clk;

    // fibonacci LFSR, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #5;
    endtask

    // plain fetch with no redirect and a harmless opcode.
    task automatic quiet_inputs;
        if_clk_en      = 1'b1;
        if_opcode      = 7'h13;
        exe_correction = '0;
        id_sel_pc      = 1'b0;
        if_prediction  = 1'b0;
        wr_en          = 1'b0;
    endtask

    task automatic random_cycle(input bit gaps);
        logic [31:0] v;
        draw(2, v);
        if_clk_en = gaps ? (v[1:0] != 2'd0) : 1'b1;
        exe_correction = '0;
        id_sel_pc      = 1'b0;
        if_prediction  = 1'b0;
        draw(3, v);
        case (v[2:0])
            3'd0: begin
                draw(2, v);
                exe_correction = (v[1:0] == 2'd0) ? 2'd1 : v[1:0];
            end
            3'd1: id_sel_pc = 1'b1;
            3'd2: if_prediction = 1'b1;
            default: ;
        endcase
        draw(12, v);
        exe_target = v[11:0];
        draw(12, v);
        id_target = v[11:0];
        draw(12, v);
        pred_target = v[11:0];
        // no URET outside the directed return.
        draw(7, v);
        if_opcode = (v[6:0] == `IRQ_URET_OP) ? (v[6:0] ^ 7'h1) : v[6:0];
        next_cycle();
    endtask

    task automatic write_reg(input irq_pkg::reg_addr_t addr, input irq_pkg::pc_t data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic issue_uret;
        quiet_inputs();
        if_opcode = `IRQ_URET_OP;
        next_cycle();
        quiet_inputs();
    endtask

    // --------------------------------------------------
    // watchdog and failure monitor
    // --------------------------------------------------

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Test failed");
        $fatal(1, "watchdog timeout, the sequence did not finish in time");
    end

    always @(negedge clk) begin
        if (dut0.chk0.err_count != 0) begin
            $display("Test failed");
            $fatal(1, "an assertion on the DUT outputs failed");
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    initial begin
        clk         = 1'b0;
        nrst        = 1'b0;
        interrupt_n = 1'b1;
        wr_addr     = '0;
        wr_data     = '0;
        rd_addr     = '0;
        exe_target  = '0;
        id_target   = '0;
        pred_target = '0;
        quiet_inputs();
        repeat (10) @(posedge clk);
        #5;
        nrst = 1'b1;

        // register write and read back, interrupts left disabled.
        write_reg(`IRQ_REG_VECTOR, 12'h2a5);
        rd_addr = `IRQ_REG_VECTOR;
        next_cycle();
        write_reg(`IRQ_REG_CTRL, 12'hffe);
        rd_addr = `IRQ_REG_CTRL;
        repeat (2) next_cycle();

        // masked request.
        interrupt_n = 1'b0;
        repeat (8) next_cycle();
        interrupt_n = 1'b1;
        next_cycle();

        // enabled request with a correction during the drain.
        write_reg(`IRQ_REG_CTRL, 12'h001);
        interrupt_n = 1'b0;
        next_cycle();
        next_cycle();
        exe_correction = 2'd2;
        exe_target     = 12'h3c0;
        next_cycle();
        exe_correction = '0;
        while (!sel_isr) next_cycle();
        interrupt_n = 1'b1;

        // some time in the handler, then return.
        repeat (12) random_cycle(1'b0);
        issue_uret();
        while (ret_isr) next_cycle();
        repeat (4) next_cycle();

        // same sequence with fetch gaps and random redirects.
        repeat (ROUNDS) begin
            repeat (10) random_cycle(1'b1);
            interrupt_n = 1'b0;
            while (!sel_isr) random_cycle(1'b1);
            interrupt_n = 1'b1;
            repeat (8) random_cycle(1'b1);
            issue_uret();
            while (ret_isr) random_cycle(1'b1);
            repeat (4) random_cycle(1'b1);
        end

        quiet_inputs();
        repeat (3) next_cycle();
        if (dut0.chk0.err_count != 0) begin
            $display("Test failed");
            $fatal(1, "assertion failures were reported");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: irq_core_top.sv
module irq_core_top (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 interrupt_n,
    input  irq_pkg::opcode_t     if_opcode,
    input  logic                 if_clk_en,
    input  irq_pkg::correction_t exe_correction,
    input  irq_pkg::pc_t         exe_target,
    input  logic                 id_sel_pc,
    input  irq_pkg::pc_t         id_target,
    input  logic                 if_prediction,
    input  irq_pkg::pc_t         pred_target,
    input  logic                 wr_en,
    input  irq_pkg::reg_addr_t   wr_addr,
    input  irq_pkg::pc_t         wr_data,
    input  irq_pkg::reg_addr_t   rd_addr,
    output irq_pkg::pc_t         pc,
    output irq_pkg::pc_t         rd_data,
    output logic                 isr_stall,
    output logic                 sel_isr,
    output logic                 ret_isr,
    output irq_pkg::pc_t         save_pc
);

    logic         irq_enable;
    irq_pkg::pc_t isr_vector;

    // configuration registers.
    irq_regs regs0 (
        .clk        (clk),
        .nrst       (nrst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .irq_enable (irq_enable),
        .isr_vector (isr_vector)
    );

    // interrupt entry and return sequencer.
    interrupt_controller ctrl0 (
        .clk            (clk),
        .nrst           (nrst),
        .pc             (pc),
        .if_opcode      (if_opcode),
        .interrupt_n    (interrupt_n),
        .irq_enable     (irq_enable),
        .exe_correction (exe_correction),
        .if_prediction  (if_prediction),
        .id_sel_pc      (id_sel_pc),
        .if_clk_en      (if_clk_en),
        .isr_stall      (isr_stall),
        .sel_isr        (sel_isr),
        .ret_isr        (ret_isr),
        .save_pc        (save_pc)
    );

    // fetch program counter.
    pc_unit pc0 (
        .clk            (clk),
        .nrst           (nrst),
        .if_clk_en      (if_clk_en),
        .isr_stall      (isr_stall),
        .sel_isr        (sel_isr),
        .ret_isr        (ret_isr),
        .isr_vector     (isr_vector),
        .save_pc        (save_pc),
        .exe_correction (exe_correction),
        .exe_target     (exe_target),
        .id_sel_pc      (id_sel_pc),
        .id_target      (id_target),
        .if_prediction  (if_prediction),
        .pred_target    (pred_target),
        .pc             (pc)
    );

endmodule

// File: irq_pkg.sv
`include "irq_cfg.svh"

package irq_pkg;

    // fetch address, word granular.
    typedef logic [`IRQ_PC_W-1:0] pc_t;

    // opcode field of the fetched instruction.
    typedef logic [`IRQ_OPCODE_W-1:0] opcode_t;

    // execute stage branch correction, nonzero means redirect.
    typedef logic [`IRQ_CORR_W-1:0] correction_t;

    // drain counter of the interrupt sequencer.
    typedef logic [`IRQ_CNT_W-1:0] drain_cnt_t;

    // configuration register address.
    typedef logic [`IRQ_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        ENTER_DRAIN,
        IN_ISR,
        RET_DRAIN
    } irq_state_t;

endpackage

// File: irq_regs.sv
`include "irq_cfg.svh"

module irq_regs (
    input  logic              clk,
    input  logic              nrst,
    input  logic              wr_en,
    input  irq_pkg::reg_addr_t wr_addr,
    input  irq_pkg::pc_t      wr_data,
    input  irq_pkg::reg_addr_t rd_addr,
    output irq_pkg::pc_t      rd_data,
    output logic              irq_enable,
    output irq_pkg::pc_t      isr_vector
);

    // --------------------------------------------------
    // write side
    // --------------------------------------------------

    // handler vector register.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            isr_vector <= `IRQ_RST_VECTOR;
        end else if (wr_en && (wr_addr == `IRQ_REG_VECTOR)) begin
            isr_vector <= wr_data;
        end
    end

    // control register, only bit 0 is implemented.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            irq_enable <= 1'b0;
        end else if (wr_en && (wr_addr == `IRQ_REG_CTRL)) begin
            irq_enable <= wr_data[0];
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------

    // combinational read decode.
    always_comb begin
        case (rd_addr)
            `IRQ_REG_VECTOR: begin
                rd_data = isr_vector;
            end
            `IRQ_REG_CTRL: begin
                // upper bits read back as zero.
                rd_data = '0;
                rd_data[0] = irq_enable;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

// File: pc_unit.sv
module pc_unit (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 if_clk_en,
    input  logic                 isr_stall,
    input  logic                 sel_isr,
    input  logic                 ret_isr,
    input  irq_pkg::pc_t         isr_vector,
    input  irq_pkg::pc_t         save_pc,
    input  irq_pkg::correction_t exe_correction,
    input  irq_pkg::pc_t         exe_target,
    input  logic                 id_sel_pc,
    input  irq_pkg::pc_t         id_target,
    input  logic                 if_prediction,
    input  irq_pkg::pc_t         pred_target,
    output irq_pkg::pc_t         pc
);

    logic         sel_q;
    logic         ret_q;
    logic         sel_rise;
    logic         ret_fall;
    irq_pkg::pc_t pc_next;

    // --------------------------------------------------
    // handler entry and exit edges
    // --------------------------------------------------

    assign sel_rise = sel_isr && !sel_q;
    assign ret_fall = !ret_isr && ret_q;

    // --------------------------------------------------
    // next fetch address
    // --------------------------------------------------

    // highest priority first.
    always_comb begin
        if (sel_rise) begin
            pc_next = isr_vector;
        end else if (ret_fall) begin
            pc_next = save_pc;
        end else if (exe_correction != '0) begin
            pc_next = exe_target;
        end else if (id_sel_pc) begin
            pc_next = id_target;
        end else if (if_prediction) begin
            pc_next = pred_target;
        end else if (isr_stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    // whole fetch path holds while if_clk_en is low.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc    <= '0;
            sel_q <= 1'b0;
            ret_q <= 1'b0;
        end else if (if_clk_en) begin
            pc    <= pc_next;
            sel_q <= sel_isr;
            ret_q <= ret_isr;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module irq_core_tb -Mdir obj_dir &&
./obj_dir/Virq_core_tb +verilator+error+limit+100 || exit 1

// File: sources.f
+incdir+.
irq_pkg.sv
irq_regs.sv
interrupt_controller.sv
pc_unit.sv
irq_core_top.sv
irq_core_assert.sv
irq_core_tb.sv
